// File: buttonConditioner.sv
`timescale 1ns/10ps

module buttonConditioner (
    input  logic              displayClock,
    input  logic              rst,
    input  logic [3:0]        btn,       // Raw, active low
    output demoPkg::buttons_t presses
);
    import demoPkg::*;

    logic [3:0] syncA;    // First synchronizer stage
    logic [3:0] syncB;    // Stable level
    logic [3:0] lastLevel;

    always_ff @(posedge displayClock) begin
        if (rst) begin
            syncA     <= '0;
            syncB     <= '0;
            lastLevel <= '0;
            presses   <= '0;
        end else begin
            syncA     <= ~btn;   // Pressed reads as one
            syncB     <= syncA;
            lastLevel <= syncB;
            // Rising edge only
            presses   <= buttons_t'(syncB & ~lastLevel);
        end
    end

    // A held button gives exactly one pulse
    assert property (@(posedge displayClock) disable iff (rst)
        (presses & $past(presses)) == '0);

endmodule

// File: demoPkg.sv
package demoPkg;

    // Demo phases, code shown on the LEDs
    typedef enum logic [2:0] {
        phaseIdle      = 3'd0,
        phaseBoot      = 3'd1,
        phaseBranch    = 3'd2,   // Branch-heavy bank
        phasePower     = 3'd3,   // Compute-heavy bank
        phaseWorkload  = 3'd4,   // Mixed bank
        phaseAnalytics = 3'd5,   // Walks all banks
        phaseComplete  = 3'd6
    } demoPhase_t;

    // Press pulses, bit order matches btn[3:0]
    typedef struct packed {
        logic start;     // BTN3
        logic abort;     // BTN2
        logic advance;   // BTN1
        logic spare;     // BTN0
    } buttons_t;

    // Slide switches, bit order matches sw[3:0]
    typedef struct packed {
        logic autoAdvance;   // SW3
        logic spare2;        // SW2
        logic spare1;        // SW1
        logic hold;          // SW0 stalls the consumer
    } switches_t;

    // One RGB LED
    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } rgb_t;

endpackage

// File: demoSequencer.sv
`timescale 1ns/10ps
`include "demo_consts.svh"

module demoSequencer (
    input  logic                displayClock,
    input  logic                rst,
    input  demoPkg::buttons_t   presses,
    input  demoPkg::switches_t  sw,
    output demoPkg::demoPhase_t phase,
    output logic                demoActive,
    output logic                phaseStart    // One cycle on every phase change
);
    import demoPkg::*;

    // Room for the threshold plus one, then saturate
    localparam int TimerBits = $clog2(`AUTO_ADVANCE_TICKS + 2);
    localparam logic [TimerBits-1:0] DwellLimit = TimerBits'(`AUTO_ADVANCE_TICKS);

    logic [TimerBits-1:0] dwellTimer;
    logic autoStep;
    logic step;

    assign autoStep = sw.autoAdvance && (dwellTimer > DwellLimit);
    assign step     = demoActive && (presses.advance || autoStep);

    always_ff @(posedge displayClock) begin
        if (rst) begin
            phase      <= phaseIdle;
            demoActive <= 1'b0;
            phaseStart <= 1'b0;
            dwellTimer <= '0;
        end else begin
            phaseStart <= 1'b0;
            if (dwellTimer <= DwellLimit) begin
                dwellTimer <= dwellTimer + 1'b1;   // Stops just past the limit
            end

            if (presses.abort) begin                        // Abort beats everything
                phase      <= phaseIdle;
                demoActive <= 1'b0;
                phaseStart <= 1'b1;
                dwellTimer <= '0;
            end else if (presses.start && !demoActive) begin
                phase      <= phaseBoot;
                demoActive <= 1'b1;
                phaseStart <= 1'b1;
                dwellTimer <= '0;
            end else if (step) begin
                if (phase == phaseComplete) begin
                    phase      <= phaseIdle;   // Demo finished
                    demoActive <= 1'b0;
                end else begin
                    phase <= demoPhase_t'(phase + 1'b1);
                end
                phaseStart <= 1'b1;
                dwellTimer <= '0;              // Fresh dwell per phase
            end
        end
    end

    // Active demo always sits in a real phase
    assert property (@(posedge displayClock) disable iff (rst)
        demoActive |-> (phase != phaseIdle));

endmodule

// File: demoTop.sv
`timescale 1ns/10ps

module demoTop (
    input  logic                    displayClock,
    input  logic                    rst,
    input  logic [3:0]              btn,     // Active low
    input  demoPkg::switches_t      sw,
    output logic [3:0]              led,
    output demoPkg::rgb_t           led5,
    output demoPkg::rgb_t           led6,
    output instrPkg::perfCounters_t perf
);
    import demoPkg::*;
    import instrPkg::*;

    buttons_t    presses;
    demoPhase_t  phase;
    logic        demoActive;
    logic        phaseStart;
    instrBeat_t  genBeat;      // Producer to buffer
    logic        genReady;
    instrBeat_t  fifoBeat;     // Buffer to consumer
    logic        fifoReady;
    logic        fifoFull;
    instrClass_t lastClass;

    buttonConditioner buttonConditioner_i (
        .displayClock(displayClock), .rst(rst), .btn(btn), .presses(presses));

    demoSequencer demoSequencer_i (
        .displayClock(displayClock), .rst(rst), .presses(presses), .sw(sw),
        .phase(phase), .demoActive(demoActive), .phaseStart(phaseStart));

    patternGenerator patternGenerator_i (
        .displayClock(displayClock), .rst(rst), .phase(phase), .demoActive(demoActive),
        .phaseStart(phaseStart), .out(genBeat), .ready(genReady));

    instrFifo instrFifo_i (
        .displayClock(displayClock), .rst(rst), .flush(phaseStart), .in(genBeat),
        .inReady(genReady), .out(fifoBeat), .outReady(fifoReady), .full(fifoFull));

    instrClassifier instrClassifier_i (
        .displayClock(displayClock), .rst(rst), .clear(phaseStart), .in(fifoBeat),
        .ready(fifoReady), .hold(sw.hold), .perf(perf), .lastClass(lastClass));

    statusDisplay statusDisplay_i (
        .displayClock(displayClock), .rst(rst), .phase(phase), .demoActive(demoActive),
        .lastClass(lastClass), .fifoFull(fifoFull), .hold(sw.hold),
        .led(led), .led5(led5), .led6(led6));

endmodule

// File: demoTopTb.sv
`timescale 1ns/10ps
`include "demo_consts.svh"

module demoTopTb;
    import demoPkg::*;
    import instrPkg::*;

    localparam logic [2:0] ActNone = 3'd0, ActStart = 3'd1, ActAdvance = 3'd2;
    localparam logic [2:0] ActAbort = 3'd3, ActHold = 3'd4;
    localparam int IsNop = 0, IsCompute = 1, IsControl = 2;
    localparam int NumRows = 19;

    // One table row, action then switches, run length and expected phase code
    typedef struct packed {
        logic [2:0]  action;
        logic [3:0]  switches;
        logic [15:0] cycles;
        logic [2:0]  phaseCode;
    } stimRow_t;

    localparam stimRow_t StimTable [NumRows] = '{
        '{ActAdvance, 4'h0, 16'd30,   3'd0},   // BTN1 while idle
        '{ActStart,   4'h0, 16'd80,   3'd1},
        '{ActAdvance, 4'h0, 16'd80,   3'd2},
        '{ActAdvance, 4'h0, 16'd80,   3'd3},
        '{ActAdvance, 4'h0, 16'd80,   3'd4},
        '{ActHold,    4'h0, 16'd150,  3'd4},
        '{ActAdvance, 4'h0, 16'd120,  3'd5},   // Analytics crosses banks
        '{ActHold,    4'h0, 16'd150,  3'd5},
        '{ActAdvance, 4'h0, 16'd60,   3'd6},
        '{ActAdvance, 4'h0, 16'd30,   3'd0},   // Past complete
        '{ActStart,   4'h0, 16'd60,   3'd1},
        '{ActAdvance, 4'h0, 16'd60,   3'd2},
        '{ActHold,    4'h0, 16'd150,  3'd2},
        '{ActAbort,   4'h0, 16'd30,   3'd0},
        '{ActStart,   4'h8, 16'd1900, 3'd1},   // Early edge of the dwell window
        '{ActNone,    4'h8, 16'd250,  3'd2},   // Late edge of the window
        '{ActNone,    4'h0, 16'd2500, 3'd2},   // SW3 off, phase holds
        '{ActHold,    4'h0, 16'd150,  3'd2},
        '{ActAbort,   4'h0, 16'd30,   3'd0}
    };

    // Pattern ROM as seen from the board, four banks of 16
    localparam instrWord_t RomMirror [`ROM_DEPTH] = '{
        32'h00108093, 32'h00208113, 32'h002081b3, 32'h40208233,
        32'h00309193, 32'h0020a2b3, 32'h0020c333, 32'h0020e3b3,
        `NOP_WORD,    32'h00110413, `NOP_WORD,    32'h408084b3,
        `NOP_WORD,    32'h00941533, `NOP_WORD,    32'h0094a5b3,
        32'h00108093, 32'h00008067, 32'h00208113, 32'hfe208ee3,
        32'h00308193, 32'h00209e63, 32'h00410213, 32'h0020ce63,
        32'h00510293, 32'h0020de63, 32'h00610313, 32'h0020ee63,
        32'h00710393, 32'h0020fe63, 32'h00810413, 32'h00000067,
        32'h002081b3, 32'h40208233, 32'h002092b3, 32'h0020d333,
        32'h4020d3b3, 32'h0020a433, 32'h0020b4b3, 32'h0020c533,
        32'h0020e5b3, 32'h0020f633, 32'h003106b3, 32'h40310733,
        32'h003117b3, 32'h00315833, 32'h403158b3, 32'h00312933,
        `NOP_WORD,    `NOP_WORD,    32'h00108093, `NOP_WORD,
        `NOP_WORD,    32'h002081b3, 32'h002081b3, 32'h002081b3,
        32'h00008067, 32'h00008067, 32'h00008067, `NOP_WORD,
        `NOP_WORD,    `NOP_WORD,    `NOP_WORD,    `NOP_WORD
    };

    logic          displayClock;
    logic          rst;
    logic [3:0]    btn;
    switches_t     sw;
    logic [3:0]    led;
    rgb_t          led5;
    rgb_t          led6;
    perfCounters_t perf;

    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    int          cycleLimit;
    int          rowUsed;            // Cycles spent in the current row
    logic [2:0]  prevCode;
    logic [31:0] lcgState;

    tbClockGen clockGen_i (.displayClock(displayClock), .rst(rst));

    demoTop demoTop_i (
        .displayClock(displayClock), .rst(rst), .btn(btn), .sw(sw),
        .led(led), .led5(led5), .led6(led6), .perf(perf));

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState >> 16;   // Upper bits are the better ones
    endfunction

    // Word k of a phase's sequence
    function automatic instrWord_t expectedWord(input logic [2:0] code, input int k);
        int bank;
        case (code)
            3'd2:    bank = 1;
            3'd3:    bank = 2;
            3'd4:    bank = 3;
            3'd5:    bank = (k / `BANK_SIZE) % 4;   // Analytics rotates
            default: bank = 0;
        endcase
        return RomMirror[bank * `BANK_SIZE + k % `BANK_SIZE];
    endfunction

    function automatic int classOf(input instrWord_t word);
        if (word == `NOP_WORD) return IsNop;
        if (word[6:0] == 7'h63 || word[6:0] == 7'h6f || word[6:0] == 7'h67) return IsControl;
        return IsCompute;
    endfunction

    // Colour of word r-1, off before the first word
    function automatic logic [2:0] expectedColour(input logic [2:0] code, input int r);
        if (r == 0) return 3'b000;
        case (classOf(expectedWord(code, r - 1)))
            IsNop:     return 3'b001;   // Blue
            IsControl: return 3'b010;   // Green
            default:   return 3'b100;   // Red
        endcase
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            $display("ERROR @%0t: %s is %0h, expected %0h", $time, what, got, expected);
            errorCount++;
        end
    endtask

    task automatic stepCycle();
        @(posedge displayClock);
        #10;   // Inputs move after the edge
        rowUsed++;
    endtask

    task automatic pressButton(input int index);
        btn[index] = 1'b0;   // Active low
        repeat (5) stepCycle();
        btn[index] = 1'b1;
    endtask

    // Class counts must equal those of the first R words
    task automatic checkCounters(input logic [2:0] code);
        int counts [3];
        counts = '{0, 0, 0};
        for (int k = 0; k < int'(perf.retired); k++) begin
            counts[classOf(expectedWord(code, k))]++;
        end
        checkValue("nop count", perf.nop, counts[IsNop]);
        checkValue("compute count", perf.compute, counts[IsCompute]);
        checkValue("control count", perf.control, counts[IsControl]);
        checkValue("class sum", perf.nop + perf.compute + perf.control, perf.retired);
    endtask

    task automatic checkRowEnd(input logic [2:0] code);
        checkValue("led phase", led, {1'b0, code});
        if (code != 3'd0) begin
            checkValue("led6 flowing", led6, 3'b011);   // Green and blue
            checkCounters(code);
        end else begin
            checkValue("led5 idle", led5, 3'b000);
            checkValue("led6 idle", led6, 3'b000);
            checkValue("retired idle", perf.retired, 0);
            checkValue("counters idle", {perf.control, perf.compute}, 0);
            checkValue("nop idle", perf.nop, 0);
        end
    endtask

    // Random stall bursts, retired must freeze during each
    task automatic holdBursts(input stimRow_t row);
        int gapLen;
        int holdLen;
        logic [15:0] frozen;
        while (rowUsed + 40 <= row.cycles) begin
            gapLen  = 2 + lcgNext() % 8;
            holdLen = 8 + lcgNext() % 16;
            repeat (gapLen) stepCycle();
            sw.hold = 1'b1;
            frozen  = perf.retired;
            repeat (holdLen) begin
                stepCycle();
                checkValue("retired under hold", perf.retired, frozen);
            end
            checkValue("led6 under hold", led6, 3'b101);   // FIFO full, no flow
            checkValue("led5 class colour", led5, expectedColour(row.phaseCode, frozen));
            sw.hold = 1'b0;
        end
    endtask

    task automatic runRow(input int idx);
        stimRow_t row;
        int startErrors;
        row         = StimTable[idx];
        startErrors = errorCount;
        rowUsed     = 0;
        sw          = switches_t'(row.switches);
        case (row.action)
            ActStart:   pressButton(3);
            ActAbort:   pressButton(2);
            ActAdvance: pressButton(1);
            default:    ;
        endcase
        if (row.phaseCode != prevCode) begin   // Wait for the phase, bounded by the row
            while (led != {1'b0, row.phaseCode} && rowUsed < row.cycles) stepCycle();
            checkValue("phase reached", led, {1'b0, row.phaseCode});
        end
        if (row.phaseCode != 3'd0) begin
            while (perf.retired == '0 && rowUsed < row.cycles) stepCycle();
            if (perf.retired == '0) begin
                $display("Row %0d: no instruction retired within %0d cycles", idx, row.cycles);
                errorCount++;
            end
        end
        if (row.action == ActHold) holdBursts(row);
        while (rowUsed < row.cycles) stepCycle();
        checkRowEnd(row.phaseCode);
        prevCode = row.phaseCode;
        $display("Row %0d action %0d phase %0d retired %0d: %s", idx, row.action,
                 row.phaseCode, perf.retired, (errorCount == startErrors) ? "ok" : "mismatch");
    endtask

    // Run limit from the table length
    always @(posedge displayClock) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycleLimit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        btn        = 4'hf;   // All released
        sw         = '0;
        lcgState   = 32'h601175f0;
        prevCode   = 3'd0;
        cycleLimit = 8 + 100;   // Reset plus margin
        for (int i = 0; i < NumRows; i++) cycleLimit += StimTable[i].cycles;
        wait (rst == 1'b0);
        stepCycle();
        checkRowEnd(3'd0);   // Everything dark after reset
        checkValue("led5 after reset", led5, 3'b000);
        $display("Reset state: %s", (errorCount == 0) ? "ok" : "mismatch");
        for (int i = 0; i < NumRows; i++) runRow(i);
        $display("Rows %0d, checks %0d, errors %0d", NumRows, checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: demo_consts.svh
`ifndef DEMO_CONSTS_SVH
`define DEMO_CONSTS_SVH

// Instruction word width, RV32
`define INSTR_WIDTH 32

// Per-phase performance counter width
`define COUNT_WIDTH 16

// Words in one workload bank
`define BANK_SIZE 16

// Whole pattern ROM, four banks
`define ROM_DEPTH 64

// Entries between producer and consumer
`define FIFO_DEPTH 4

// Dwell cycles before auto-advance with SW3 on
`define AUTO_ADVANCE_TICKS 2000

// Canonical nop, addi x0,x0,0
`define NOP_WORD 32'h0000_0013

`endif

// File: instrClassifier.sv
`timescale 1ns/10ps
`include "demo_consts.svh"

module instrClassifier (
    input  logic                    displayClock,
    input  logic                    rst,
    input  logic                    clear,
    input  instrPkg::instrBeat_t    in,
    output logic                    ready,
    input  logic                    hold,
    output instrPkg::perfCounters_t perf,
    output instrPkg::instrClass_t   lastClass
);
    import instrPkg::*;

    // RV32I control-flow opcodes
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;

    instrClass_t wordClass;
    logic        accept;

    function automatic instrClass_t classify(input instrWord_t word);
        if (word == `NOP_WORD) begin
            return classNop;    // Only the exact canonical nop
        end
        case (word[6:0])
            OpBranch, OpJal, OpJalr: return classControl;
            default:                 return classCompute;
        endcase
    endfunction

    assign ready     = !hold;                // SW0 freezes the consumer
    assign accept    = in.valid && ready;
    assign wordClass = classify(in.word);

    always_ff @(posedge displayClock) begin
        if (rst || clear) begin
            perf      <= '0;
            lastClass <= classNone;
        end else if (accept) begin
            perf.retired <= perf.retired + 1'b1;
            case (wordClass)
                classNop:     perf.nop     <= perf.nop + 1'b1;
                classControl: perf.control <= perf.control + 1'b1;
                default:      perf.compute <= perf.compute + 1'b1;
            endcase
            lastClass <= wordClass;
        end
    end

    // Class counts always add up to retired
    assert property (@(posedge displayClock) disable iff (rst)
        perf.retired == count_t'(perf.control + perf.compute + perf.nop));

endmodule

// File: instrFifo.sv
`timescale 1ns/10ps
`include "demo_consts.svh"

module instrFifo (
    input  logic                 displayClock,
    input  logic                 rst,
    input  logic                 flush,
    input  instrPkg::instrBeat_t in,
    output logic                 inReady,
    output instrPkg::instrBeat_t out,
    input  logic                 outReady,
    output logic                 full
);
    import instrPkg::*;

    localparam int PtrBits   = $clog2(`FIFO_DEPTH);
    localparam int CountBits = $clog2(`FIFO_DEPTH + 1);

    instrWord_t           mem [`FIFO_DEPTH];
    logic [PtrBits-1:0]   wrPtr;
    logic [PtrBits-1:0]   rdPtr;
    logic [CountBits-1:0] count;
    logic push;
    logic pop;

    function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
        return (ptr == PtrBits'(`FIFO_DEPTH - 1)) ? '0 : PtrBits'(ptr + 1'b1);
    endfunction

    assign full      = (count == CountBits'(`FIFO_DEPTH));
    assign inReady   = !full;
    assign out.valid = (count != '0);
    assign out.word  = mem[rdPtr];           // Head of queue
    assign push      = in.valid && inReady;
    assign pop       = out.valid && outReady;

    always_ff @(posedge displayClock) begin
        if (push) begin
            mem[wrPtr] <= in.word;
        end
    end

    always_ff @(posedge displayClock) begin
        if (rst || flush) begin   // Flush empties on the phaseStart edge
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= nextPtr(wrPtr);
            if (pop)  rdPtr <= nextPtr(rdPtr);
            case ({push, pop})
                2'b10:   count <= CountBits'(count + 1'b1);
                2'b01:   count <= CountBits'(count - 1'b1);
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // Write when full or read when empty drives count out of range
    assert property (@(posedge displayClock) disable iff (rst)
        count <= CountBits'(`FIFO_DEPTH));
    // Pointers meet only when empty or full
    assert property (@(posedge displayClock) disable iff (rst)
        (count == '0 || full) |-> (wrPtr == rdPtr));

endmodule

// File: instrPkg.sv
`include "demo_consts.svh"

package instrPkg;

    typedef logic [`INSTR_WIDTH-1:0] instrWord_t;
    typedef logic [`COUNT_WIDTH-1:0] count_t;

    // Class of the last retired word
    typedef enum logic [1:0] {
        classNone    = 2'd0,   // Nothing retired since clear
        classNop     = 2'd1,
        classCompute = 2'd2,
        classControl = 2'd3    // Branch, jal, jalr
    } instrClass_t;

    // One beat of the valid/ready stream
    typedef struct packed {
        logic       valid;
        instrWord_t word;
    } instrBeat_t;

    // Per-phase counts, cleared on phaseStart
    typedef struct packed {
        count_t retired;
        count_t control;
        count_t compute;
        count_t nop;
    } perfCounters_t;

endpackage

// File: patternGenerator.sv
`timescale 1ns/10ps
`include "demo_consts.svh"

module patternGenerator (
    input  logic                 displayClock,
    input  logic                 rst,
    input  demoPkg::demoPhase_t  phase,
    input  logic                 demoActive,
    input  logic                 phaseStart,
    output instrPkg::instrBeat_t out,
    input  logic                 ready
);
    import demoPkg::*;
    import instrPkg::*;

    localparam int RomBits  = $clog2(`ROM_DEPTH);
    localparam int BankBits = $clog2(`BANK_SIZE);
    localparam int SelBits  = RomBits - BankBits;

    localparam instrWord_t PatternRom [`ROM_DEPTH] = '{
        // Bank 0 basic ALU mix with nops
        32'h00108093, 32'h00208113, 32'h002081b3, 32'h40208233,
        32'h00309193, 32'h0020a2b3, 32'h0020c333, 32'h0020e3b3,
        `NOP_WORD,    32'h00110413, `NOP_WORD,    32'h408084b3,
        `NOP_WORD,    32'h00941533, `NOP_WORD,    32'h0094a5b3,
        // Bank 1 branch heavy
        32'h00108093, 32'h00008067, 32'h00208113, 32'hfe208ee3,
        32'h00308193, 32'h00209e63, 32'h00410213, 32'h0020ce63,
        32'h00510293, 32'h0020de63, 32'h00610313, 32'h0020ee63,
        32'h00710393, 32'h0020fe63, 32'h00810413, 32'h00000067,
        // Bank 2 compute heavy, all R-type
        32'h002081b3, 32'h40208233, 32'h002092b3, 32'h0020d333,
        32'h4020d3b3, 32'h0020a433, 32'h0020b4b3, 32'h0020c533,
        32'h0020e5b3, 32'h0020f633, 32'h003106b3, 32'h40310733,
        32'h003117b3, 32'h00315833, 32'h403158b3, 32'h00312933,
        // Bank 3 mixed workload
        `NOP_WORD,    `NOP_WORD,    32'h00108093, `NOP_WORD,
        `NOP_WORD,    32'h002081b3, 32'h002081b3, 32'h002081b3,
        32'h00008067, 32'h00008067, 32'h00008067, `NOP_WORD,
        `NOP_WORD,    `NOP_WORD,    `NOP_WORD,    `NOP_WORD
    };

    logic [RomBits-1:0] wordIndex;    // Next word of the phase sequence
    logic [RomBits-1:0] fetchIndex;
    logic [RomBits-1:0] romAddr;
    logic [SelBits-1:0] bankSel;

    always_comb begin
        fetchIndex = phaseStart ? '0 : wordIndex;   // New phase restarts at word 0
        case (phase)
            phaseBranch:    bankSel = SelBits'(1);
            phasePower:     bankSel = SelBits'(2);
            phaseWorkload:  bankSel = SelBits'(3);
            phaseAnalytics: bankSel = fetchIndex[RomBits-1:BankBits];   // Walk all banks
            default:        bankSel = '0;                               // Idle, boot, complete
        endcase
        romAddr = {bankSel, fetchIndex[BankBits-1:0]};
    end

    always_ff @(posedge displayClock) begin
        if (rst) begin
            out.valid <= 1'b0;
            wordIndex <= '0;
        end else if (phaseStart || !out.valid || ready) begin   // Slot free or pending dropped
            out.valid <= demoActive;                            // Silent while idle
            out.word  <= PatternRom[romAddr];
            wordIndex <= demoActive ? RomBits'(fetchIndex + 1'b1) : '0;
        end
    end

    // Offered word holds until taken
    assert property (@(posedge displayClock) disable iff (rst)
        (out.valid && !ready && !phaseStart) |=> (out.valid && $stable(out.word)));

endmodule

// File: src.f
+incdir+.
demoPkg.sv
instrPkg.sv
buttonConditioner.sv
demoSequencer.sv
patternGenerator.sv
instrFifo.sv
instrClassifier.sv
statusDisplay.sv
demoTop.sv
tbClockGen.sv
demoTopTb.sv

// File: statusDisplay.sv
`timescale 1ns/10ps

module statusDisplay (
    input  logic                  displayClock,
    input  logic                  rst,
    input  demoPkg::demoPhase_t   phase,
    input  logic                  demoActive,
    input  instrPkg::instrClass_t lastClass,
    input  logic                  fifoFull,
    input  logic                  hold,
    output logic [3:0]            led,
    output demoPkg::rgb_t         led5,
    output demoPkg::rgb_t         led6
);
    import demoPkg::*;
    import instrPkg::*;

    localparam rgb_t RgbOff   = '{red: 1'b0, green: 1'b0, blue: 1'b0};
    localparam rgb_t RgbRed   = '{red: 1'b1, green: 1'b0, blue: 1'b0};
    localparam rgb_t RgbGreen = '{red: 1'b0, green: 1'b1, blue: 1'b0};
    localparam rgb_t RgbBlue  = '{red: 1'b0, green: 1'b0, blue: 1'b1};

    function automatic rgb_t classColour(input instrClass_t cls);
        case (cls)
            classNop:     return RgbBlue;
            classCompute: return RgbRed;
            classControl: return RgbGreen;
            default:      return RgbOff;   // Nothing retired yet
        endcase
    endfunction

    always_ff @(posedge displayClock) begin
        if (rst) begin
            led  <= '0;
            led5 <= RgbOff;
            led6 <= RgbOff;
        end else if (demoActive) begin
            led  <= {1'b0, phase};         // Phase code 1 to 6
            led5 <= classColour(lastClass);

            // Pipeline health on LD6
            led6.red   <= fifoFull;        // Buffer backed up
            led6.green <= !hold;           // Consumer flowing
            led6.blue  <= 1'b1;            // Demo running
        end else begin
            led  <= '0;
            led5 <= RgbOff;
            led6 <= RgbOff;
        end
    end

endmodule

// File: tbClockGen.sv
`timescale 1ns/10ps

module tbClockGen (
    output logic displayClock,
    output logic rst
);
    localparam realtime Period = 100.0;   // 10 MHz
    localparam int ResetCycles = 8;

    initial begin
        displayClock = 1'b0;
        forever #(Period / 2) displayClock = ~displayClock;
    end

    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge displayClock);
        #10 rst = 1'b0;   // Released with the other inputs
    end

endmodule
